//--- Makefile
# Verilator flow for the two-port scratchpad memory.
# Any variable below can be overridden on the command line.

VERILATOR ?= verilator
FILELIST  ?= project.f
TB_TOP    ?= mem_tb
RTL_TOP   ?= mem_subsys_top
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?=
PASS_MSG  ?= *** PASSED ***

SIM_BIN := $(BUILD_DIR)/V$(TB_TOP)

.PHONY: all lint build sim clean

all: sim

# Lint the synthesizable top level with all warnings enabled.
lint:
	$(VERILATOR) --lint-only -Wall --timing $(VFLAGS) \
		-f $(FILELIST) --top-module $(RTL_TOP)

build:
	$(VERILATOR) --binary --timing --assert $(VFLAGS) \
		-f $(FILELIST) --top-module $(TB_TOP) -Mdir $(BUILD_DIR)

# The run counts as passed only if the log holds the pass line.
sim: build
	./$(SIM_BIN) 2>&1 | tee $(LOG)
	@grep -F -q -- '$(PASS_MSG)' $(LOG) || \
		(echo "Simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- design/mem_2rw_sync.sv
`default_nettype none

`include "mem_cfg.svh"

module mem_2rw_sync
  #(
    parameter int unsigned WIDTH        = `MEM_WIDTH,
    parameter int unsigned ELS          = `MEM_ELS,
    parameter bit          CLOCK_GATING = `MEM_CLOCK_GATING
  )
  (
    input  logic              clk_i,
    input  logic              rst_i,
    input  mem_pkg::mem_req_t a_req_i,
    input  mem_pkg::mem_req_t b_req_i,
    output logic [WIDTH-1:0]  a_data_o,
    output logic [WIDTH-1:0]  b_data_o
  );

  logic clk_lo;
  logic gate_en;

  // The array needs its clock whenever either port has work. Reset also
  // opens the gate, since the output registers clear synchronously.
  assign gate_en = a_req_i.v | b_req_i.v | rst_i;

  if (CLOCK_GATING)
  begin : g_gated
    mem_clkgate u_clkgate
      (
        .clk_i         (clk_i),
        .en_i          (gate_en),
        .bypass_i      (1'b0),
        .gated_clock_o (clk_lo)
      );
  end
  else
  begin : g_free
    // gate_en has no load here
    assign clk_lo = clk_i;
  end

  mem_2rw_sync_synth
    #(
      .WIDTH (WIDTH),
      .ELS   (ELS)
    )
    u_synth
    (
      .clk_i    (clk_lo),
      .rst_i    (rst_i),
      .a_req_i  (a_req_i),
      .b_req_i  (b_req_i),
      .a_data_o (a_data_o),
      .b_data_o (b_data_o)
    );

endmodule

`default_nettype wire

//--- design/mem_2rw_sync_synth.sv
`default_nettype none

`include "mem_cfg.svh"

module mem_2rw_sync_synth
  #(
    parameter int unsigned WIDTH = `MEM_WIDTH,
    parameter int unsigned ELS   = `MEM_ELS
  )
  (
    input  logic              clk_i,
    input  logic              rst_i,
    input  mem_pkg::mem_req_t a_req_i,
    input  mem_pkg::mem_req_t b_req_i,
    output logic [WIDTH-1:0]  a_data_o,
    output logic [WIDTH-1:0]  b_data_o
  );

  logic [WIDTH-1:0] mem [ELS];

  logic a_wr;
  logic a_rd;
  logic b_wr;
  logic b_rd;

  // The request carries a data word of fixed width, and its address must
  // be able to reach the last word.
  if (WIDTH != `MEM_WIDTH)
  begin : g_width_check
    $error("WIDTH %0d differs from the request data width %0d", WIDTH, `MEM_WIDTH);
  end

  if (ELS > (1 << `MEM_ADDR_W))
  begin : g_els_check
    $error("ELS %0d exceeds the request address range", ELS);
  end

  assign a_wr = a_req_i.v & a_req_i.w;
  assign a_rd = a_req_i.v & ~a_req_i.w;
  assign b_wr = b_req_i.v & b_req_i.w;
  assign b_rd = b_req_i.v & ~b_req_i.w;

  // Port A is written last, so it wins if both ports ever hit one word.
  always_ff @(posedge clk_i)
  begin
    if (b_wr)
    begin
      mem[b_req_i.addr] <= b_req_i.data;
    end
    if (a_wr)
    begin
      mem[a_req_i.addr] <= a_req_i.data;
    end
  end

  // Both ports sample the array before this edge's writes land, which
  // gives read-first behaviour against a write on the other port.
  // Each output holds until the next read on its own port.
  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      a_data_o <= '0;
      b_data_o <= '0;
    end
    else
    begin
      if (a_rd)
      begin
        a_data_o <= mem[a_req_i.addr];
      end
      if (b_rd)
      begin
        b_data_o <= mem[b_req_i.addr];
      end
    end
  end

endmodule

`default_nettype wire

//--- design/mem_cfg.svh
`ifndef MEM_CFG_SVH
`define MEM_CFG_SVH

// Default geometry of the scratchpad.

// Width of one data word in bits.
`define MEM_WIDTH 32

// Number of words in the array. It is not a power of two, so part of the
// address space lies above the last word.
`define MEM_ELS 200

// Address width, wide enough to reach every word.
`define MEM_ADDR_W ($clog2(`MEM_ELS))

// Set to 1 to stop the array clock in cycles with no access.
`define MEM_CLOCK_GATING 1

`endif

//--- design/mem_clkgate.sv
`default_nettype none

module mem_clkgate
  (
    input  logic clk_i,
    input  logic en_i,
    input  logic bypass_i,
    output logic gated_clock_o
  );

  logic en_latched;

  // The enable passes the latch only while the clock is low. It is stable
  // for the whole high phase, so the AND below cannot make a glitch.
  always_latch
  begin
    if (!clk_i)
    begin
      en_latched = en_i | bypass_i;
    end
  end

  assign gated_clock_o = clk_i & en_latched;

endmodule

`default_nettype wire

//--- design/mem_pkg.sv
`default_nettype none

`include "mem_cfg.svh"

package mem_pkg;

  // One access request on a memory port.
  // A set w bit makes the request a write, a clear one a read.
  typedef struct packed {
    logic                   v;
    logic                   w;
    logic [`MEM_ADDR_W-1:0] addr;
    logic [`MEM_WIDTH-1:0]  data;
  } mem_req_t;

  // Status flags from the request guard.
  // Each flag describes the requests of the previous cycle.
  typedef struct packed {
    logic a_range_err;
    logic b_range_err;
    logic ww_collision;
  } mem_status_t;

endpackage

`default_nettype wire

//--- design/mem_req_guard.sv
`default_nettype none

`include "mem_cfg.svh"

module mem_req_guard
  #(
    parameter int unsigned ELS = `MEM_ELS
  )
  (
    input  logic                 clk_i,
    input  logic                 rst_i,
    input  mem_pkg::mem_req_t    a_req_i,
    input  mem_pkg::mem_req_t    b_req_i,
    output mem_pkg::mem_req_t    a_req_o,
    output mem_pkg::mem_req_t    b_req_o,
    output mem_pkg::mem_status_t status_o
  );

  import mem_pkg::*;

  localparam int unsigned ADDR_W = `MEM_ADDR_W;

  // One bit wider than the address, so that a full power-of-two count
  // still compares correctly.
  localparam logic [ADDR_W:0] ELS_LIM = (ADDR_W + 1)'(ELS);

  logic        a_range;
  logic        b_range;
  logic        a_ok;
  logic        b_ok;
  logic        ww;
  mem_status_t status_d;

  assign a_range = a_req_i.v & ({1'b0, a_req_i.addr} >= ELS_LIM);
  assign b_range = b_req_i.v & ({1'b0, b_req_i.addr} >= ELS_LIM);

  assign a_ok = a_req_i.v & ~a_range;
  assign b_ok = b_req_i.v & ~b_range;

  // Two in-range writes to one word. Port A keeps its write.
  assign ww = a_ok & b_ok & a_req_i.w & b_req_i.w & (a_req_i.addr == b_req_i.addr);

  // A dropped request passes on with only its valid bit cleared.
  always_comb
  begin
    a_req_o   = a_req_i;
    a_req_o.v = a_ok;
    b_req_o   = b_req_i;
    b_req_o.v = b_ok & ~ww;
  end

  always_comb
  begin
    status_d              = '0;
    status_d.a_range_err  = a_range;
    status_d.b_range_err  = b_range;
    status_d.ww_collision = ww;
  end

  // The flags are one-cycle pulses, one cycle after the offending request.
  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      status_o <= '0;
    end
    else
    begin
      status_o <= status_d;
    end
  end

endmodule

`default_nettype wire

//--- design/mem_subsys_top.sv
`default_nettype none

`include "mem_cfg.svh"

module mem_subsys_top
  (
    input  logic                    clk_i,
    input  logic                    rst_i,
    input  mem_pkg::mem_req_t       a_req_i,
    input  mem_pkg::mem_req_t       b_req_i,
    output logic [`MEM_WIDTH-1:0]   a_data_o,
    output logic [`MEM_WIDTH-1:0]   b_data_o,
    output mem_pkg::mem_status_t    status_o
  );

  import mem_pkg::*;

  // Requests after range and collision filtering.
  mem_req_t a_req;
  mem_req_t b_req;

  mem_req_guard
    #(
      .ELS (`MEM_ELS)
    )
    u_guard
    (
      .clk_i    (clk_i),
      .rst_i    (rst_i),
      .a_req_i  (a_req_i),
      .b_req_i  (b_req_i),
      .a_req_o  (a_req),
      .b_req_o  (b_req),
      .status_o (status_o)
    );

  // Every request that reaches the memory is in range and free of
  // write-write collisions.
  mem_2rw_sync
    #(
      .WIDTH        (`MEM_WIDTH),
      .ELS          (`MEM_ELS),
      .CLOCK_GATING (`MEM_CLOCK_GATING)
    )
    u_mem
    (
      .clk_i    (clk_i),
      .rst_i    (rst_i),
      .a_req_i  (a_req),
      .b_req_i  (b_req),
      .a_data_o (a_data_o),
      .b_data_o (b_data_o)
    );

endmodule

`default_nettype wire

//--- project.f
+incdir+design
design/mem_pkg.sv
design/mem_clkgate.sv
design/mem_2rw_sync_synth.sv
design/mem_2rw_sync.sv
design/mem_req_guard.sv
design/mem_subsys_top.sv
tests/mem_props.sv
tests/mem_tb.sv

//--- tests/mem_props.sv
`default_nettype none

`include "mem_cfg.svh"

module mem_props
  #(
    parameter int unsigned WIDTH = `MEM_WIDTH,
    parameter int unsigned ELS   = `MEM_ELS
  )
  (
    input  logic              clk_i,
    input  logic              rst_i,
    input  mem_pkg::mem_req_t a_req_i,
    input  mem_pkg::mem_req_t b_req_i,
    input  logic [WIDTH-1:0]  a_data_o,
    input  logic [WIDTH-1:0]  b_data_o
  );

  // The guard must keep every request that reaches the array inside it.
  a_addr_in_range: assert property (@(posedge clk_i) disable iff (rst_i)
    a_req_i.v |-> (32'(a_req_i.addr) < ELS))
    else $error("port A address %0d reached the array, above %0d words", a_req_i.addr, ELS);

  b_addr_in_range: assert property (@(posedge clk_i) disable iff (rst_i)
    b_req_i.v |-> (32'(b_req_i.addr) < ELS))
    else $error("port B address %0d reached the array, above %0d words", b_req_i.addr, ELS);

  no_same_word_writes: assert property (@(posedge clk_i) disable iff (rst_i)
    !(a_req_i.v && a_req_i.w && b_req_i.v && b_req_i.w && (a_req_i.addr == b_req_i.addr)))
    else $error("both ports wrote word %0d in one cycle", a_req_i.addr);

  outputs_clear_after_reset: assert property (@(posedge clk_i)
    rst_i |=> ((a_data_o == '0) && (b_data_o == '0)))
    else $error("read outputs were not zero after reset");

endmodule

bind mem_2rw_sync mem_props
  #(
    .WIDTH (WIDTH),
    .ELS   (ELS)
  )
  u_props
  (
    .clk_i    (clk_i),
    .rst_i    (rst_i),
    .a_req_i  (a_req_i),
    .b_req_i  (b_req_i),
    .a_data_o (a_data_o),
    .b_data_o (b_data_o)
  );

`default_nettype wire

//--- tests/mem_tb.sv
`default_nettype none

`include "mem_cfg.svh"

module mem_tb;

  import mem_pkg::*;

  localparam int W           = `MEM_WIDTH;
  localparam int ADDR_W      = `MEM_ADDR_W;
  localparam int ELS         = `MEM_ELS;
  localparam int DRAIN_LIMIT = 8;

  typedef struct packed {
    logic [W-1:0] a_data;
    logic [W-1:0] b_data;
    mem_status_t  status;
  } expect_t;

  logic         clk;
  logic         rst;
  mem_req_t     a_req;
  mem_req_t     b_req;
  logic [W-1:0] a_data;
  logic [W-1:0] b_data;
  mem_status_t  status;

  logic [31:0]  seed = 32'hfce5_68f5;

  // Model of the array and of the two held read outputs.
  logic [W-1:0] model_mem [ELS];
  logic [W-1:0] model_a;
  logic [W-1:0] model_b;

  expect_t      exp_q [$];
  string        name_q [$];
  int           pending;
  int           checks;
  int           fails;
  int           tests;
  int           mark_checks;
  int           mark_fails;

  mem_subsys_top UUT
    (
      .clk_i    (clk),
      .rst_i    (rst),
      .a_req_i  (a_req),
      .b_req_i  (b_req),
      .a_data_o (a_data),
      .b_data_o (b_data),
      .status_o (status)
    );

  initial
  begin
    clk = 1'b0;
    forever
    begin
      #4 clk = ~clk;
    end
  end

  function automatic logic [31:0] next_rand();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  function automatic logic [ADDR_W-1:0] rand_addr();
    logic [31:0] r;
    r = (next_rand() >> 8) % 32'(ELS);
    return r[ADDR_W-1:0];
  endfunction

  // An address in the hole between the last word and the top of the space.
  function automatic logic [ADDR_W-1:0] rand_bad_addr();
    logic [31:0] r;
    r = 32'(ELS) + (next_rand() >> 8) % 32'((1 << ADDR_W) - ELS);
    return r[ADDR_W-1:0];
  endfunction

  function automatic mem_req_t make_req(logic v, logic w, logic [ADDR_W-1:0] addr,
                                        logic [W-1:0] data);
    mem_req_t r;
    r.v    = v;
    r.w    = w;
    r.addr = addr;
    r.data = data;
    return r;
  endfunction

  // Out-of-range requests are dropped, and so is B's write when both ports
  // write one word. Reads see the array as it was before this cycle's writes.
  function automatic expect_t model_step(mem_req_t a, mem_req_t b);
    expect_t e;
    logic    a_bad;
    logic    b_bad;
    logic    a_go;
    logic    b_go;
    logic    ww;
    a_bad = a.v && (32'(a.addr) >= 32'(ELS));
    b_bad = b.v && (32'(b.addr) >= 32'(ELS));
    a_go  = a.v && !a_bad;
    b_go  = b.v && !b_bad;
    ww    = a_go && b_go && a.w && b.w && (a.addr == b.addr);
    b_go  = b_go && !ww;
    if (a_go && !a.w)
    begin
      model_a = model_mem[a.addr];
    end
    if (b_go && !b.w)
    begin
      model_b = model_mem[b.addr];
    end
    if (b_go && b.w)
    begin
      model_mem[b.addr] = b.data;
    end
    if (a_go && a.w)
    begin
      model_mem[a.addr] = a.data;
    end
    e.a_data              = model_a;
    e.b_data              = model_b;
    e.status.a_range_err  = a_bad;
    e.status.b_range_err  = b_bad;
    e.status.ww_collision = ww;
    return e;
  endfunction

  task automatic check_val(string name, string what, logic [W-1:0] expected,
                           logic [W-1:0] actual);
    checks++;
    if (actual !== expected)
    begin
      fails++;
      $display("FAIL %s %s: expected %h, actual %h", name, what, expected, actual);
    end
  endtask

  task automatic drive_cycle(string name, mem_req_t a, mem_req_t b);
    @(negedge clk);
    a_req = a;
    b_req = b;
    exp_q.push_back(model_step(a, b));
    name_q.push_back(name);
    pending++;
  endtask

  task automatic end_run();
    $display("%0d tests, %0d checks, %0d mismatches", tests, checks, fails);
    if (fails == 0)
    begin
      $display("*** PASSED ***");
    end
    else
    begin
      $display("*** FAILED ***");
    end
    $finish;
  endtask

  // One idle cycle parks the inputs, then the checker catches up.
  task automatic finish_test(string name);
    int waited;
    drive_cycle(name, make_req(1'b0, 1'b0, '0, '0), make_req(1'b0, 1'b0, '0, '0));
    waited = 0;
    while (pending != 0 && waited < DRAIN_LIMIT)
    begin
      @(posedge clk);
      waited++;
    end
    if (pending != 0)
    begin
      $display("ERROR: test %s left %0d cycles unchecked after %0d clocks",
               name, pending, DRAIN_LIMIT);
      fails++;
    end
    else
    begin
      $display("test %-14s done, %0d checks, %0d mismatches",
               name, checks - mark_checks, fails - mark_fails);
    end
    tests++;
    mark_checks = checks;
    mark_fails  = fails;
  endtask

  // Each request is checked at the falling edge after the edge that took it.
  initial
  begin
    expect_t e;
    string   name;
    forever
    begin
      @(posedge clk);
      if (exp_q.size() > 0)
      begin
        e    = exp_q.pop_front();
        name = name_q.pop_front();
        @(negedge clk);
        check_val(name, "a_data_o", e.a_data, a_data);
        check_val(name, "b_data_o", e.b_data, b_data);
        check_val(name, "status_o", W'(e.status), W'(status));
        pending--;
      end
    end
  end

  initial
  begin
    mem_req_t          a;
    mem_req_t          b;
    mem_req_t          idle;
    logic [ADDR_W-1:0] x;
    logic [W-1:0]      d;
    logic [31:0]       r;
    idle        = make_req(1'b0, 1'b0, '0, '0);
    rst         = 1'b1;
    a_req       = idle;
    b_req       = idle;
    model_a     = '0;
    model_b     = '0;
    pending     = 0;
    checks      = 0;
    fails       = 0;
    tests       = 0;
    mark_checks = 0;
    mark_fails  = 0;
    repeat (3) @(negedge clk);
    rst = 1'b0;

    drive_cycle("reset_zero", idle, idle);
    drive_cycle("reset_zero", idle, idle);
    finish_test("reset_zero");

    // A fills the even words and B the odd ones. Each port then reads the other's.
    for (int i = 0; i < ELS / 2; i++)
    begin
      a = make_req(1'b1, 1'b1, ADDR_W'(2 * i), next_rand());
      b = make_req(1'b1, 1'b1, ADDR_W'(2 * i + 1), next_rand());
      drive_cycle("fill_readback", a, b);
    end
    for (int i = 0; i < 60; i++)
    begin
      x = rand_addr();
      a = make_req(1'b1, 1'b0, {x[ADDR_W-1:1], 1'b1}, '0);
      x = rand_addr();
      b = make_req(1'b1, 1'b0, {x[ADDR_W-1:1], 1'b0}, '0);
      drive_cycle("fill_readback", a, b);
    end
    finish_test("fill_readback");

    for (int i = 0; i < 8; i++)
    begin
      x = rand_addr();
      d = next_rand();
      if (i % 2 == 0)
      begin
        a = make_req(1'b1, 1'b1, x, d);
        b = make_req(1'b1, 1'b0, x, '0);
      end
      else
      begin
        a = make_req(1'b1, 1'b0, x, '0);
        b = make_req(1'b1, 1'b1, x, d);
      end
      drive_cycle("read_first", a, b);
      drive_cycle("read_first", make_req(1'b1, 1'b0, x, '0), make_req(1'b1, 1'b0, x, '0));
    end
    finish_test("read_first");

    for (int i = 0; i < 6; i++)
    begin
      x = rand_addr();
      a = make_req(1'b1, 1'b1, x, next_rand());
      b = make_req(1'b1, 1'b1, x, next_rand());
      drive_cycle("ww_collision", a, b);
      drive_cycle("ww_collision", idle, idle);
      drive_cycle("ww_collision", make_req(1'b1, 1'b0, x, '0), make_req(1'b1, 1'b0, x, '0));
    end
    finish_test("ww_collision");

    for (int i = 0; i < 8; i++)
    begin
      a = make_req(1'b1, i[0], rand_bad_addr(), next_rand());
      if (i < 4)
      begin
        b = make_req(1'b1, ~i[0], rand_bad_addr(), next_rand());
      end
      else
      begin
        b = make_req(1'b1, 1'b0, rand_addr(), '0);
      end
      drive_cycle("range_error", a, b);
    end
    finish_test("range_error");

    drive_cycle("gated_idle", make_req(1'b1, 1'b0, rand_addr(), '0),
                make_req(1'b1, 1'b0, rand_addr(), '0));
    for (int i = 0; i < 5; i++)
    begin
      drive_cycle("gated_idle", idle, idle);
    end
    drive_cycle("gated_idle", make_req(1'b1, 1'b0, rand_addr(), '0),
                make_req(1'b1, 1'b0, rand_addr(), '0));
    finish_test("gated_idle");

    // A narrow window around the last word mixes collisions with range errors.
    for (int i = 0; i < 200; i++)
    begin
      r = next_rand();
      a = make_req(r[31] | r[30], r[29], ADDR_W'(ELS - 4) + ADDR_W'(r[28:26]), next_rand());
      b = make_req(r[25] | r[24], r[23], ADDR_W'(ELS - 4) + ADDR_W'(r[22:20]), next_rand());
      drive_cycle("random_mix", a, b);
    end
    finish_test("random_mix");

    end_run();
  end

endmodule

`default_nettype wire
